//--- Bender.yml
package:
  name: router_output_port

sources:
  - include_dirs:
      - include
    files:
      - hdl/routerPkg.sv
      - hdl/portTimer.sv
      - hdl/switchArbiter.sv
      - hdl/outputRegister.sv
      - hdl/routerOutputPort.sv
  - target: test
    files:
      - test/tb_routerOutputPort.sv

//--- hdl/outputRegister.sv
`timescale 1ns/1ns

module outputRegister
  import routerPkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  grantT grant,
  input  flitT  lFlit,
  input  flitT  nFlit,
  input  flitT  eFlit,
  input  flitT  wFlit,
  input  flitT  sFlit,
  input  logic  lReq,
  input  logic  nReq,
  input  logic  eReq,
  input  logic  wReq,
  input  logic  sReq,
  output flitT  outFlit,
  output logic  outValid,
  output grantT outPort
);

  flitT selFlit;
  logic selReq;

  always_comb
  begin
    selFlit = '0;
    selReq  = 1'b0;   // idle selects nothing.
    case (grant)
      GRANT_L:
      begin
        selFlit = lFlit;
        selReq  = lReq;
      end
      GRANT_N:
      begin
        selFlit = nFlit;
        selReq  = nReq;
      end
      GRANT_E:
      begin
        selFlit = eFlit;
        selReq  = eReq;
      end
      GRANT_W:
      begin
        selFlit = wFlit;
        selReq  = wReq;
      end
      GRANT_S:
      begin
        selFlit = sFlit;
        selReq  = sReq;
      end
      default:
      begin
        selFlit = '0;
        selReq  = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      outFlit  <= '0;
      outValid <= 1'b0;
      outPort  <= GRANT_IDLE;
    end
    else
    begin
      outFlit  <= selFlit;
      outValid <= selReq;
      outPort  <= grant;
    end
  end

  validHasPort: assert property (
    @(posedge clk) disable iff (rst)
      outValid |-> (outPort != GRANT_IDLE)
  )
  else
    $error("outputRegister: valid flit with idle port");

endmodule

//--- hdl/portTimer.sv
`timescale 1ns/1ns

module portTimer
  import routerPkg::*;
(
  input  logic   clk,
  input  logic   rst,
  input  flitIdT flitId,
  input  lenT    length,
  input  logic   runTimer,
  output logic   timesUp
);

  lenT limit;   // hold bound from the last header.
  lenT count;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      limit <= '0;
      count <= '0;
    end
    else
    begin
      if (flitId == FLIT_HEAD)
      begin
        limit <= length;   // latched even while not granted.
      end
      if (runTimer)
      begin
        count <= count + 1'b1;
      end
      else
      begin
        count <= '0;
      end
    end
  end

  assign timesUp = (count == limit);

  // the arbiter stops running the timer once the limit is hit,
  // so a header that shrinks the limit mid-hold shows up here.
  countWithinLimit: assert property (
    @(posedge clk) disable iff (rst)
      runTimer |-> (count <= limit)
  )
  else
    $error("portTimer: count passed the hold limit");

endmodule

//--- hdl/routerOutputPort.sv
`timescale 1ns/1ns
`include "router_params.svh"

module routerOutputPort
  import routerPkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  flitT  lFlit,
  input  flitT  nFlit,
  input  flitT  eFlit,
  input  flitT  wFlit,
  input  flitT  sFlit,
  input  logic  lReq,
  input  logic  nReq,
  input  logic  eReq,
  input  logic  wReq,
  input  logic  sReq,
  output flitT  outFlit,
  output logic  outValid,
  output grantT outPort
);

  flitIdT lFlitId;
  flitIdT nFlitId;
  flitIdT eFlitId;
  flitIdT wFlitId;
  flitIdT sFlitId;
  lenT    lLength;
  lenT    nLength;
  lenT    eLength;
  lenT    wLength;
  lenT    sLength;
  grantT  grant;

  // flit kind from the top bits.
  assign lFlitId = lFlit[`FLIT_W-1 -: `FLIT_ID_W];
  assign nFlitId = nFlit[`FLIT_W-1 -: `FLIT_ID_W];
  assign eFlitId = eFlit[`FLIT_W-1 -: `FLIT_ID_W];
  assign wFlitId = wFlit[`FLIT_W-1 -: `FLIT_ID_W];
  assign sFlitId = sFlit[`FLIT_W-1 -: `FLIT_ID_W];

  // length, meaningful on header flits only.
  assign lLength = lFlit[`LEN_W-1:0];
  assign nLength = nFlit[`LEN_W-1:0];
  assign eLength = eFlit[`LEN_W-1:0];
  assign wLength = wFlit[`LEN_W-1:0];
  assign sLength = sFlit[`LEN_W-1:0];

  switchArbiter arbiter (
    .clk     (clk),
    .rst     (rst),
    .lFlitId (lFlitId),
    .nFlitId (nFlitId),
    .eFlitId (eFlitId),
    .wFlitId (wFlitId),
    .sFlitId (sFlitId),
    .lLength (lLength),
    .nLength (nLength),
    .eLength (eLength),
    .wLength (wLength),
    .sLength (sLength),
    .lReq    (lReq),
    .nReq    (nReq),
    .eReq    (eReq),
    .wReq    (wReq),
    .sReq    (sReq),
    .grant   (grant)
  );

  outputRegister outReg (
    .clk      (clk),
    .rst      (rst),
    .grant    (grant),
    .lFlit    (lFlit),
    .nFlit    (nFlit),
    .eFlit    (eFlit),
    .wFlit    (wFlit),
    .sFlit    (sFlit),
    .lReq     (lReq),
    .nReq     (nReq),
    .eReq     (eReq),
    .wReq     (wReq),
    .sReq     (sReq),
    .outFlit  (outFlit),
    .outValid (outValid),
    .outPort  (outPort)
  );

endmodule

//--- hdl/routerPkg.sv
`include "router_params.svh"

package routerPkg;

  typedef logic [`FLIT_W-1:0] flitT;
  typedef logic [`FLIT_ID_W-1:0] flitIdT;
  typedef logic [`LEN_W-1:0] lenT;

  // one-hot, bit 0 idle, bits 1..5 are L, N, E, W, S.
  typedef logic [`NUM_PORTS:0] grantT;

  localparam flitIdT FLIT_HEAD = 3'd1;
  localparam flitIdT FLIT_BODY = 3'd2;
  localparam flitIdT FLIT_TAIL = 3'd3;

  localparam grantT GRANT_IDLE = 6'b000001;
  localparam grantT GRANT_L    = 6'b000010;
  localparam grantT GRANT_N    = 6'b000100;
  localparam grantT GRANT_E    = 6'b001000;
  localparam grantT GRANT_W    = 6'b010000;
  localparam grantT GRANT_S    = 6'b100000;

endpackage

//--- hdl/switchArbiter.sv
`timescale 1ns/1ns
`include "router_params.svh"

module switchArbiter
  import routerPkg::*;
(
  input  logic   clk,
  input  logic   rst,
  input  flitIdT lFlitId,
  input  flitIdT nFlitId,
  input  flitIdT eFlitId,
  input  flitIdT wFlitId,
  input  flitIdT sFlitId,
  input  lenT    lLength,
  input  lenT    nLength,
  input  lenT    eLength,
  input  lenT    wLength,
  input  lenT    sLength,
  input  logic   lReq,
  input  logic   nReq,
  input  logic   eReq,
  input  logic   wReq,
  input  logic   sReq,
  output grantT  grant
);

  logic [`NUM_PORTS-1:0] reqVec;       // bit 0 is L.
  logic [`NUM_PORTS-1:0] timesUpVec;
  logic [`NUM_PORTS-1:0] runTimer;
  grantT                 nextGrant;
  int                    holder;       // index of the granted input.
  logic                  legal;

  // first requester among the span inputs that follow last.
  function automatic grantT pickAfter(input logic [`NUM_PORTS-1:0] reqs,
                                      input int last,
                                      input int span);
    grantT pick;
    logic  found;
    int    idx;
    pick  = GRANT_IDLE;
    found = 1'b0;
    for (int k = 1; k <= `NUM_PORTS; k++)
    begin
      idx = (last + k) % `NUM_PORTS;
      if ((k <= span) && !found && reqs[idx])
      begin
        pick  = grantT'(1) << (idx + 1);
        found = 1'b1;
      end
    end
    return pick;
  endfunction

  assign reqVec = {sReq, wReq, eReq, nReq, lReq};

  portTimer lTimer (
    .clk      (clk),
    .rst      (rst),
    .flitId   (lFlitId),
    .length   (lLength),
    .runTimer (runTimer[0]),
    .timesUp  (timesUpVec[0])
  );

  portTimer nTimer (
    .clk      (clk),
    .rst      (rst),
    .flitId   (nFlitId),
    .length   (nLength),
    .runTimer (runTimer[1]),
    .timesUp  (timesUpVec[1])
  );

  portTimer eTimer (
    .clk      (clk),
    .rst      (rst),
    .flitId   (eFlitId),
    .length   (eLength),
    .runTimer (runTimer[2]),
    .timesUp  (timesUpVec[2])
  );

  portTimer wTimer (
    .clk      (clk),
    .rst      (rst),
    .flitId   (wFlitId),
    .length   (wLength),
    .runTimer (runTimer[3]),
    .timesUp  (timesUpVec[3])
  );

  portTimer sTimer (
    .clk      (clk),
    .rst      (rst),
    .flitId   (sFlitId),
    .length   (sLength),
    .runTimer (runTimer[4]),
    .timesUp  (timesUpVec[4])
  );

  always_comb
  begin
    holder = 0;
    legal  = 1'b1;
    case (grant)
      GRANT_IDLE: holder = `NUM_PORTS - 1;   // scan then starts at L.
      GRANT_L:    holder = 0;
      GRANT_N:    holder = 1;
      GRANT_E:    holder = 2;
      GRANT_W:    holder = 3;
      GRANT_S:    holder = 4;
      default:    legal = 1'b0;
    endcase
  end

  always_comb
  begin
    runTimer  = '0;
    nextGrant = GRANT_IDLE;
    if (!legal)
    begin
      nextGrant = GRANT_IDLE;   // recover to idle.
    end
    else if (grant == GRANT_IDLE)
    begin
      nextGrant = pickAfter(reqVec, holder, `NUM_PORTS);
    end
    else if (reqVec[holder] && !timesUpVec[holder])
    begin
      runTimer[holder] = 1'b1;   // hold and keep counting.
      nextGrant        = grant;
    end
    else
    begin
      nextGrant = pickAfter(reqVec, holder, `NUM_PORTS - 1);
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      grant <= GRANT_IDLE;
    end
    else
    begin
      grant <= nextGrant;
    end
  end

  grantOneHot: assert property (
    @(posedge clk) disable iff (rst)
      $onehot(grant)
  )
  else
    $error("switchArbiter: grant is not one-hot");

  // a handover from a held port lands only on an input that was requesting.
  grantToRequester: assert property (
    @(posedge clk) disable iff (rst)
      (grant != GRANT_IDLE) |=>
        (grant == $past(grant)) || (grant == GRANT_IDLE) ||
        ((grant[`NUM_PORTS:1] & $past(reqVec)) != '0)
  )
  else
    $error("switchArbiter: grant moved to an idle input");

endmodule

//--- include/router_params.svh
`ifndef ROUTER_PARAMS_SVH
`define ROUTER_PARAMS_SVH

// inputs in rotation order L, N, E, W, S.
`define NUM_PORTS 5

// full flit word.
`define FLIT_W 32

// flit kind, top bits of every flit.
`define FLIT_ID_W 3

// packet length, low bits of a header flit.
`define LEN_W 12

`endif

//--- sim.f
+incdir+include
hdl/routerPkg.sv
hdl/portTimer.sv
hdl/switchArbiter.sv
hdl/outputRegister.sv
hdl/routerOutputPort.sv
test/tb_routerOutputPort.sv

//--- test/router_golden.txt
# test reqs(LNEWS) lFlit nFlit eFlit wFlit sFlit expValid expPort expFlit
# expected columns are the outputs one clock after the line is driven
1 00000 00000000 00000000 00000000 00000000 00000000 0 000001 00000000
1 00000 00000000 00000000 00000000 00000000 00000000 0 000001 00000000
1 00000 00000000 00000000 00000000 00000000 00000000 0 000001 00000000
1 00000 00000000 00000000 00000000 00000000 00000000 0 000001 00000000
2 01101 00000000 40000011 40000021 00000000 40000051 0 000001 00000000
2 01101 00000000 40000012 40000022 00000000 40000052 1 000100 40000012
2 01101 00000000 40000013 40000023 00000000 40000053 1 001000 40000023
2 00001 00000000 00000000 00000000 00000000 40000054 1 100000 40000054
2 00000 00000000 00000000 00000000 00000000 00000000 0 000001 00000000
3 10100 20000003 00000000 40000031 00000000 00000000 0 000001 00000000
3 10100 40000101 00000000 40000032 00000000 00000000 1 000010 40000101
3 10100 40000102 00000000 40000033 00000000 00000000 1 000010 40000102
3 10100 40000103 00000000 40000034 00000000 00000000 1 000010 40000103
3 10100 60000104 00000000 40000035 00000000 00000000 1 000010 60000104
3 00100 00000000 00000000 40000036 00000000 00000000 1 001000 40000036
3 00000 00000000 00000000 00000000 00000000 00000000 0 000001 00000000
4 10000 20000005 00000000 00000000 00000000 00000000 0 000001 00000000
4 10000 40000201 20000002 00000000 00000000 00000000 1 000010 40000201
4 01000 00000000 40000211 00000000 00000000 00000000 0 000010 00000000
4 01000 00000000 40000212 00000000 00000000 00000000 1 000100 40000212
4 01000 00000000 40000213 00000000 00000000 00000000 1 000100 40000213
4 01000 00000000 60000214 00000000 00000000 00000000 1 000100 60000214
4 00000 00000000 00000000 00000000 00000000 00000000 0 000001 00000000
5 00010 00000000 00000000 00000000 20000001 00000000 0 000001 00000000
5 11010 40000501 40000502 00000000 40000401 00000000 1 010000 40000401
5 11010 40000503 40000504 00000000 60000402 00000000 1 010000 60000402
5 11000 40000506 40000507 00000000 00000000 00000000 1 000010 40000506
5 00000 00000000 00000000 00000000 00000000 00000000 0 000010 00000000
5 00000 00000000 00000000 00000000 00000000 00000000 0 000001 00000000

//--- test/tb_routerOutputPort.sv
`timescale 1ns/1ns

module tb_routerOutputPort
  import routerPkg::*;
();

  logic  clk;
  logic  rst;
  flitT  lFlit;
  flitT  nFlit;
  flitT  eFlit;
  flitT  wFlit;
  flitT  sFlit;
  logic  lReq;
  logic  nReq;
  logic  eReq;
  logic  wReq;
  logic  sReq;
  flitT  outFlit;
  logic  outValid;
  grantT outPort;

  // one entry per golden line.
  int         testNum[$];
  logic [4:0] reqBits[$];   // L is bit 4.
  flitT       lFlitQ[$];
  flitT       nFlitQ[$];
  flitT       eFlitQ[$];
  flitT       wFlitQ[$];
  flitT       sFlitQ[$];
  logic       expValidQ[$];
  grantT      expPortQ[$];
  flitT       expFlitQ[$];

  int cycleCount;
  int cycleLimit;
  int testErrors;
  int passedTests;
  int failedTests;

  routerOutputPort i_dut (
    .clk      (clk),
    .rst      (rst),
    .lFlit    (lFlit),
    .nFlit    (nFlit),
    .eFlit    (eFlit),
    .wFlit    (wFlit),
    .sFlit    (sFlit),
    .lReq     (lReq),
    .nReq     (nReq),
    .eReq     (eReq),
    .wReq     (wReq),
    .sReq     (sReq),
    .outFlit  (outFlit),
    .outValid (outValid),
    .outPort  (outPort)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic readGolden(output bit ok);
    int         fd;
    int         lineNo;
    int         got;
    string      text;
    int         tNum;
    logic [4:0] reqs;
    flitT       fl;
    flitT       fn;
    flitT       fe;
    flitT       fw;
    flitT       fs;
    flitT       ef;
    logic       ev;
    grantT      ep;
    ok     = 1'b0;
    lineNo = 0;
    fd     = $fopen("test/router_golden.txt", "r");
    if (fd == 0)
    begin
      $display("cannot open the golden file test/router_golden.txt");
      return;
    end
    while (!$feof(fd))
    begin
      text = "";
      got  = $fgets(text, fd);
      lineNo++;
      if ((got == 0) || (text.len() < 2) || (text[0] == "#"))
        continue;   // blank or column note.
      got = $sscanf(text, "%d %b %h %h %h %h %h %b %b %h",
                    tNum, reqs, fl, fn, fe, fw, fs, ev, ep, ef);
      if (got != 10)
      begin
        $display("golden file line %0d is short, it has %0d of 10 fields", lineNo, got);
        $fclose(fd);
        return;
      end
      testNum.push_back(tNum);
      reqBits.push_back(reqs);
      lFlitQ.push_back(fl);
      nFlitQ.push_back(fn);
      eFlitQ.push_back(fe);
      wFlitQ.push_back(fw);
      sFlitQ.push_back(fs);
      expValidQ.push_back(ev);
      expPortQ.push_back(ep);
      expFlitQ.push_back(ef);
    end
    $fclose(fd);
    if (testNum.size() == 0)
    begin
      $display("the golden file holds no test lines");
      return;
    end
    ok = 1'b1;
  endtask

  task automatic applyLine(input int idx);
    lReq  <= reqBits[idx][4];
    nReq  <= reqBits[idx][3];
    eReq  <= reqBits[idx][2];
    wReq  <= reqBits[idx][1];
    sReq  <= reqBits[idx][0];
    lFlit <= lFlitQ[idx];
    nFlit <= nFlitQ[idx];
    eFlit <= eFlitQ[idx];
    wFlit <= wFlitQ[idx];
    sFlit <= sFlitQ[idx];
  endtask

  task automatic finishTest(input int tNum);
    if (testErrors == 0)
    begin
      $display("test %0d: ok", tNum);
      passedTests++;
    end
    else
    begin
      $display("test %0d: %0d mismatches", tNum, testErrors);
      failedTests++;
    end
    testErrors = 0;
  endtask

  // outputs seen one clock after line idx was driven.
  task automatic checkLine(input int idx);
    assert (outValid === expValidQ[idx])
    else
    begin
      $display("FAILED at %0t ns: outValid is %b, expected %b (line %0d)",
               $time, outValid, expValidQ[idx], idx);
      testErrors++;
    end
    assert (outPort === expPortQ[idx])
    else
    begin
      $display("FAILED at %0t ns: outPort is %b, expected %b (line %0d)",
               $time, outPort, expPortQ[idx], idx);
      testErrors++;
    end
    assert (outFlit === expFlitQ[idx])
    else
    begin
      $display("FAILED at %0t ns: outFlit is %h, expected %h (line %0d)",
               $time, outFlit, expFlitQ[idx], idx);
      testErrors++;
    end
    if ((idx == testNum.size() - 1) || (testNum[idx + 1] != testNum[idx]))
      finishTest(testNum[idx]);
  endtask

  task automatic checkReset();
    assert ((outValid === 1'b0) && (outPort === GRANT_IDLE) && (outFlit === '0))
    else
    begin
      $display("FAILED at %0t ns: outValid %b, outPort %b, outFlit %h after reset",
               $time, outValid, outPort, outFlit);
      testErrors++;
    end
  endtask

  task automatic runGolden();
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    checkReset();
    for (int i = 0; i < testNum.size(); i++)
    begin
      @(posedge clk);
      applyLine(i);
      if (i > 0)
      begin
        @(negedge clk);
        checkLine(i - 1);
      end
    end
    @(posedge clk);
    @(negedge clk);
    checkLine(testNum.size() - 1);
  endtask

  initial
  begin : main
    bit fileOk;
    rst         = 1'b1;
    lReq        = 1'b0;
    nReq        = 1'b0;
    eReq        = 1'b0;
    wReq        = 1'b0;
    sReq        = 1'b0;
    lFlit       = '0;
    nFlit       = '0;
    eFlit       = '0;
    wFlit       = '0;
    sFlit       = '0;
    testErrors  = 0;
    passedTests = 0;
    failedTests = 0;
    readGolden(fileOk);
    if (!fileOk)
    begin
      $display("tests failed");
    end
    else
    begin
      cycleLimit = 2 * testNum.size() + 20;
      runGolden();
      $display("summary: %0d passed, %0d failed", passedTests, failedTests);
      if (failedTests == 0)
        $display("all tests passed");
      else
        $display("tests failed");
    end
    $finish;
  end

  initial
  begin : watchdog
    cycleCount = 0;
    wait (cycleLimit > 0);
    while (cycleCount < cycleLimit)
    begin
      @(posedge clk);
      cycleCount++;
    end
    $display("timeout: the run went past %0d clock cycles", cycleLimit);
    $display("tests failed");
    $finish;
  end

endmodule
